//--- design/if_cfg.svh
// fetch stage constants; FIFO depth should be a power of two, trap base plus 8 bits fills XLEN
`ifndef IF_CFG_SVH
`define IF_CFG_SVH

// ---------------------------------------------------------------------------
// datapath widths
// ---------------------------------------------------------------------------
`define IF_XLEN            32            // address and instruction width
`define IF_TRAP_BASE_W     24            // mtvec/utvec base, upper bits only
`define IF_VEC_W           5             // vectored irq index

// debug module entry point
`define IF_DM_HALT_ADDR    32'h1A11_0800

// ---------------------------------------------------------------------------
// prefetch sizing
// ---------------------------------------------------------------------------
`define IF_FIFO_DEPTH      2             // instruction FIFO entries
`define IF_MAX_OUTSTANDING 2             // memory requests in flight

// no compressed instructions, so the pc always moves by a full word
`define IF_INSTR_BYTES     4

`endif

//--- design/if_pkg.sv
// fetch stage types; sel encodings must match what the controller in ID drives
`default_nettype none

`include "if_cfg.svh"

package if_pkg;

  // next pc source, same codes as the controller uses
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_FENCEI    = 3'b001,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_MRET      = 3'b101,
    PC_URET      = 3'b110,
    PC_DRET      = 3'b111
  } pc_sel_e;

  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'b00,  // sync exception, base only
    EXC_PC_IRQ       = 2'b01,  // vectored interrupt
    EXC_PC_DEBUG     = 2'b10   // debug halt address
  } exc_sel_e;

  typedef enum logic {
    TRAP_MACHINE = 1'b0,
    TRAP_USER    = 1'b1
  } trap_sel_e;

  // ---------------------------------------------------------------------------
  // bundles
  // ---------------------------------------------------------------------------
  typedef struct packed {
    logic [`IF_XLEN-1:0] boot_addr;  // low two bits ignored
    logic [`IF_XLEN-1:0] jump_id;    // jump target from ID
    logic [`IF_XLEN-1:0] branch_ex;  // branch target from EX
    logic [`IF_XLEN-1:0] mepc;
    logic [`IF_XLEN-1:0] uepc;
    logic [`IF_XLEN-1:0] depc;
  } redirect_t;

  typedef struct packed {
    logic [`IF_TRAP_BASE_W-1:0] m_base;
    logic [`IF_TRAP_BASE_W-1:0] u_base;
    trap_sel_e                  trap_sel;
    exc_sel_e                   exc_sel;
    logic [`IF_VEC_W-1:0]       vec_idx;
  } trap_ctrl_t;

  typedef struct packed {
    logic                req;
    logic [`IF_XLEN-1:0] addr;
  } imem_req_t;

  typedef struct packed {
    logic                gnt;
    logic                rvalid;
    logic [`IF_XLEN-1:0] rdata;
  } imem_rsp_t;

  // one buffered word and the address it was fetched from
  typedef struct packed {
    logic [`IF_XLEN-1:0] addr;
    logic [`IF_XLEN-1:0] instr;
  } fetch_item_t;

  typedef struct packed {
    logic                valid;
    logic [`IF_XLEN-1:0] instr;
    logic [`IF_XLEN-1:0] pc;
  } id_bundle_t;

endpackage

`default_nettype wire

//--- design/if_next_pc.sv
// pure comb next-pc mux; fetch address is always forced to a 4-byte boundary
`timescale 1ns/10ps
`default_nettype none

`include "if_cfg.svh"

module if_next_pc (
  input  if_pkg::pc_sel_e     pc_mux_i,      // redirect source
  input  if_pkg::redirect_t   redirect_i,    // all candidate targets
  input  if_pkg::trap_ctrl_t  trap_ctrl_i,   // base, mode and irq index
  input  logic [`IF_XLEN-1:0] pc_id_i,       // pc held in IF/ID
  output logic [`IF_XLEN-1:0] fetch_addr_o   // word aligned target
);

  logic [`IF_TRAP_BASE_W-1:0] trap_base;
  logic [`IF_XLEN-1:0]        exc_pc;
  logic [`IF_XLEN-1:0]        next_pc;

  // ---------------------------------------------------------------------------
  // trap vector
  // ---------------------------------------------------------------------------
  always_comb begin : trap_vec
    trap_base = trap_ctrl_i.m_base;  // machine mode unless told otherwise
    if (trap_ctrl_i.trap_sel == if_pkg::TRAP_USER) begin
      trap_base = trap_ctrl_i.u_base;
    end

    exc_pc = {trap_base, 8'h00};
    unique case (trap_ctrl_i.exc_sel)
      if_pkg::EXC_PC_EXCEPTION: exc_pc = {trap_base, 8'h00};  // all exceptions share base
      if_pkg::EXC_PC_IRQ:       exc_pc = {trap_base, 1'b0, trap_ctrl_i.vec_idx, 2'b00};
      if_pkg::EXC_PC_DEBUG:     exc_pc = `IF_DM_HALT_ADDR;
      default:                  exc_pc = {trap_base, 8'h00};
    endcase
  end

  // ---------------------------------------------------------------------------
  // fetch address select
  // ---------------------------------------------------------------------------
  always_comb begin : pc_mux
    next_pc = '0;
    unique case (pc_mux_i)
      if_pkg::PC_BOOT:      next_pc = {redirect_i.boot_addr[`IF_XLEN-1:2], 2'b00};
      if_pkg::PC_JUMP:      next_pc = redirect_i.jump_id;
      if_pkg::PC_BRANCH:    next_pc = redirect_i.branch_ex;
      if_pkg::PC_EXCEPTION: next_pc = exc_pc;             // handler entry
      if_pkg::PC_MRET:      next_pc = redirect_i.mepc;    // back from machine trap
      if_pkg::PC_URET:      next_pc = redirect_i.uepc;    // back from user trap
      if_pkg::PC_DRET:      next_pc = redirect_i.depc;    // leave debug mode
      // refetch everything after the fence
      if_pkg::PC_FENCEI:    next_pc = pc_id_i + `IF_XLEN'(`IF_INSTR_BYTES);
      default:              next_pc = '0;
    endcase
  end

  // memory only sees whole words
  assign fetch_addr_o = {next_pc[`IF_XLEN-1:2], 2'b00};

endmodule

`default_nettype wire

//--- design/if_prefetch_buffer.sv
// in-order memory only; responses after a branch are counted and dropped, not cancelled
`timescale 1ns/10ps
`default_nettype none

`include "if_cfg.svh"

module if_prefetch_buffer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_i,          // keep fetching sequentially
  input  logic                branch_i,       // flush and restart at branch_addr_i
  input  logic [`IF_XLEN-1:0] branch_addr_i,
  input  logic                ready_i,        // pop, only honoured while valid_o
  input  if_pkg::imem_rsp_t   imem_rsp_i,
  output logic                valid_o,
  output if_pkg::fetch_item_t item_o,
  output if_pkg::imem_req_t   imem_req_o,
  output logic                busy_o
);

  localparam int CW = $clog2(`IF_MAX_OUTSTANDING + 1);  // in-flight counter
  localparam int FW = $clog2(`IF_FIFO_DEPTH + 1);       // fifo fill level
  localparam int PW = (`IF_FIFO_DEPTH > 1) ? $clog2(`IF_FIFO_DEPTH) : 1;
  localparam int SW = ((CW > FW) ? CW : FW) + 1;        // sum without overflow

  logic [`IF_XLEN-1:0] addr_q;        // next sequential request
  logic [`IF_XLEN-1:0] rsp_addr_q;    // address of next kept response
  logic                started_q;     // a branch has set addr_q
  logic [CW-1:0]       out_cnt_q;     // accepted, rvalid not yet seen
  logic [CW-1:0]       discard_q;     // of those, belonging to a dead path
  logic [CW-1:0]       out_cnt_n;
  logic [CW-1:0]       discard_n;

  if_pkg::fetch_item_t fifo_mem [`IF_FIFO_DEPTH];
  logic [PW-1:0]       wr_ptr_q;
  logic [PW-1:0]       rd_ptr_q;
  logic [FW-1:0]       fifo_cnt_q;

  logic [SW-1:0]       occupancy;
  logic                room;
  logic                below_max;
  logic                accept;
  logic                drop;
  logic                push;
  logic                pop;

  // ---------------------------------------------------------------------------
  // request side
  // ---------------------------------------------------------------------------
  // live responses will land in the fifo, so they reserve a slot already
  assign occupancy = SW'(fifo_cnt_q) + SW'(out_cnt_q - discard_q);
  assign room      = occupancy < SW'(`IF_FIFO_DEPTH);
  assign below_max = out_cnt_q < CW'(`IF_MAX_OUTSTANDING);

  always_comb begin : req_gen
    // a branch empties the fifo, so only the in-flight limit applies
    imem_req_o.req  = below_max & (branch_i | (started_q & req_i & room));
    imem_req_o.addr = branch_i ? branch_addr_i : addr_q;  // held until gnt
  end

  assign accept = imem_req_o.req & imem_rsp_i.gnt;

  // ---------------------------------------------------------------------------
  // response side
  // ---------------------------------------------------------------------------
  assign drop = imem_rsp_i.rvalid & (branch_i | (discard_q != '0));  // old path
  assign push = imem_rsp_i.rvalid & ~drop;
  assign pop  = ready_i & valid_o & ~branch_i;

  assign out_cnt_n = out_cnt_q + CW'(accept) - CW'(imem_rsp_i.rvalid);

  always_comb begin : discard_calc
    discard_n = discard_q;
    if (branch_i) begin
      discard_n = out_cnt_q - CW'(imem_rsp_i.rvalid);  // everything still out is stale
    end else if (drop) begin
      discard_n = discard_q - CW'(1);
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin : ctrl_regs
    if (!rst_n) begin
      addr_q     <= '0;
      rsp_addr_q <= '0;
      started_q  <= 1'b0;
      out_cnt_q  <= '0;
      discard_q  <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else begin
      out_cnt_q <= out_cnt_n;
      discard_q <= discard_n;
      started_q <= started_q | branch_i;

      if (branch_i) begin
        addr_q     <= accept ? branch_addr_i + `IF_XLEN'(`IF_INSTR_BYTES) : branch_addr_i;
        rsp_addr_q <= branch_addr_i;  // first kept response is the target
        wr_ptr_q   <= '0;             // flush
        rd_ptr_q   <= '0;
        fifo_cnt_q <= '0;
      end else begin
        if (accept) addr_q <= addr_q + `IF_XLEN'(`IF_INSTR_BYTES);
        if (push) begin
          rsp_addr_q <= rsp_addr_q + `IF_XLEN'(`IF_INSTR_BYTES);
          wr_ptr_q   <= (wr_ptr_q == PW'(`IF_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + PW'(1);
        end
        if (pop) begin
          rd_ptr_q <= (rd_ptr_q == PW'(`IF_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + PW'(1);
        end
        fifo_cnt_q <= fifo_cnt_q + FW'(push) - FW'(pop);
      end
    end
  end

  // storage, no reset needed
  always_ff @(posedge clk) begin : fifo_write
    if (push) begin
      fifo_mem[wr_ptr_q] <= '{addr: rsp_addr_q, instr: imem_rsp_i.rdata};
    end
  end

  assign valid_o = fifo_cnt_q != '0;     // new word visible one cycle after rvalid
  assign item_o  = fifo_mem[rd_ptr_q];
  assign busy_o  = (out_cnt_q != '0) | imem_req_o.req;

  // ---------------------------------------------------------------------------
  // assertions
  // ---------------------------------------------------------------------------
  // memory may only grant what we ask for
  a_gnt_needs_req : assert property (@(posedge clk) disable iff (!rst_n)
    imem_rsp_i.gnt |-> imem_req_o.req)
    else $error("grant without a request");

  // every rvalid answers an earlier accepted request
  a_rvalid_owed : assert property (@(posedge clk) disable iff (!rst_n)
    imem_rsp_i.rvalid |-> (out_cnt_q != '0))
    else $error("rvalid with nothing outstanding");

endmodule

`default_nettype wire

//--- design/if_fetch_ctrl.sv
// 32-bit words only, no offset handling; IF/ID loads only while ID is ready and not halted
`timescale 1ns/10ps
`default_nettype none

`include "if_cfg.svh"

module if_fetch_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_i,               // core wants instructions
  input  logic                pc_set_i,            // redirect this cycle
  input  logic                fetch_valid_i,       // prefetch fifo not empty
  input  if_pkg::fetch_item_t fetch_item_i,
  input  logic                clear_instr_valid_i, // kill the word in ID
  input  logic                halt_if_i,
  input  logic                id_ready_i,
  output logic                branch_req_o,        // load new address into prefetcher
  output logic                fetch_ready_o,       // pop
  output if_pkg::id_bundle_t  id_o,
  output logic                perf_imiss_o
);

  enum logic [0:0] {IDLE, WAIT} state_q, state_n;

  logic               valid;      // item offered to ID
  logic               branch_req;
  logic               if_valid;   // item taken into IF/ID
  if_pkg::id_bundle_t id_q;

  // ---------------------------------------------------------------------------
  // offset FSM
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk, negedge rst_n) begin : fsm_reg
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  always_comb begin : fsm_next
    state_n    = state_q;
    branch_req = 1'b0;
    valid      = 1'b0;

    unique case (state_q)
      // nothing fetched yet, first req starts at the boot target
      IDLE: begin
        if (req_i) begin
          branch_req = 1'b1;
          state_n    = WAIT;
        end
      end
      // hand the fifo head to ID
      WAIT: begin
        valid = fetch_valid_i & req_i;
      end
      default: state_n = IDLE;
    endcase

    // redirect wins, whatever the state
    if (pc_set_i) begin
      valid      = 1'b0;  // head belongs to the old path
      branch_req = 1'b1;
      state_n    = WAIT;
    end
  end

  assign if_valid      = valid & id_ready_i & ~halt_if_i;
  assign fetch_ready_o = if_valid;  // pop exactly what ID takes
  assign branch_req_o  = branch_req;
  assign perf_imiss_o  = ~fetch_valid_i | branch_req;

  // ---------------------------------------------------------------------------
  // IF/ID register, frozen while ID stalls
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk, negedge rst_n) begin : if_id_reg
    if (!rst_n) begin
      id_q <= '0;
    end else if (if_valid) begin
      id_q.valid <= 1'b1;
      id_q.instr <= fetch_item_i.instr;
      id_q.pc    <= fetch_item_i.addr;
    end else if (clear_instr_valid_i) begin
      id_q.valid <= 1'b0;  // pc stays for fence.i
    end
  end

  assign id_o = id_q;

  // stall or halt must not disturb what ID is decoding
  a_id_hold : assert property (@(posedge clk) disable iff (!rst_n)
    ((!id_ready_i || halt_if_i) && !clear_instr_valid_i) |=> $stable(id_q))
    else $error("IF/ID changed while ID stalled or IF halted");

endmodule

`default_nettype wire

//--- design/if_stage.sv
// fetch stage top; single 32-bit instruction memory port, no compressed or loop support
`timescale 1ns/10ps
`default_nettype none

`include "if_cfg.svh"

module if_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_i,
  input  logic                pc_set_i,
  input  if_pkg::pc_sel_e     pc_mux_i,
  input  if_pkg::redirect_t   redirect_i,
  input  if_pkg::trap_ctrl_t  trap_ctrl_i,
  input  logic                clear_instr_valid_i,
  input  logic                halt_if_i,
  input  logic                id_ready_i,
  input  if_pkg::imem_rsp_t   imem_rsp_i,
  output if_pkg::imem_req_t   imem_req_o,
  output if_pkg::id_bundle_t  id_o,
  output logic [`IF_XLEN-1:0] pc_if_o,       // address of the fifo head
  output logic                if_busy_o,
  output logic                perf_imiss_o
);

  logic [`IF_XLEN-1:0] fetch_addr;   // redirect target, comb
  logic                branch_req;
  logic                fetch_valid;
  logic                fetch_ready;
  if_pkg::fetch_item_t fetch_item;

  // ---------------------------------------------------------------------------
  // next pc, prefetch, fetch control
  // ---------------------------------------------------------------------------
  if_next_pc u_next_pc (
    .pc_mux_i     (pc_mux_i),
    .redirect_i   (redirect_i),
    .trap_ctrl_i  (trap_ctrl_i),
    .pc_id_i      (id_o.pc),     // fence.i restarts after the ID instruction
    .fetch_addr_o (fetch_addr)
  );

  if_prefetch_buffer u_prefetch (
    .clk (clk), .rst_n (rst_n),
    .req_i (req_i), .branch_i (branch_req), .branch_addr_i (fetch_addr),
    .ready_i (fetch_ready), .imem_rsp_i (imem_rsp_i),
    .valid_o (fetch_valid), .item_o (fetch_item),
    .imem_req_o (imem_req_o), .busy_o (if_busy_o)
  );

  if_fetch_ctrl u_fetch_ctrl (
    .clk (clk), .rst_n (rst_n),
    .req_i (req_i), .pc_set_i (pc_set_i),
    .fetch_valid_i (fetch_valid), .fetch_item_i (fetch_item),
    .clear_instr_valid_i (clear_instr_valid_i), .halt_if_i (halt_if_i),
    .id_ready_i (id_ready_i), .branch_req_o (branch_req),
    .fetch_ready_o (fetch_ready), .id_o (id_o), .perf_imiss_o (perf_imiss_o)
  );

  assign pc_if_o = fetch_item.addr;

endmodule

`default_nettype wire

//--- verif/tb_if_stage.sv
// in-order memory model with random gnt/rvalid delays; redirect targets must differ from id pc
`timescale 1ns/10ps
`default_nettype none

`include "if_cfg.svh"

module tb_if_stage;

  localparam logic [`IF_XLEN-1:0] RDATA_MASK = 32'hA5A5_0000;  // memory data = addr ^ mask
  localparam int WAIT_LIMIT = 200;                              // cycles per wait

  logic clk = 1'b0;
  logic rst_n;
  logic req, pc_set, clear_valid, halt_if, id_ready;
  if_pkg::pc_sel_e     pc_mux;
  if_pkg::redirect_t   targets;
  if_pkg::trap_ctrl_t  trap_ctrl;
  if_pkg::imem_rsp_t   imem_rsp;
  if_pkg::imem_req_t   imem_req;
  if_pkg::id_bundle_t  id_bundle;
  logic [`IF_XLEN-1:0] pc_if;
  logic                if_busy, perf_imiss;

  logic                gnt_en, rsp_rvalid;
  logic [`IF_XLEN-1:0] rsp_rdata;
  logic [`IF_XLEN-1:0] pend_q [$];  // accepted, not yet answered
  logic [31:0]         lfsr_q;

  logic                booted;      // req has been raised once
  logic                redir;       // a redirect is issued this cycle
  logic [`IF_XLEN-1:0] redir_pc;
  logic [`IF_XLEN-1:0] exp_pc;      // pc of the next item ID should get
  logic                last_valid_q;
  logic [`IF_XLEN-1:0] last_pc_q;
  logic                new_item;
  int                  loads;

  always #10 clk = ~clk;

  if_stage dut0 (
    .clk (clk), .rst_n (rst_n), .req_i (req), .pc_set_i (pc_set), .pc_mux_i (pc_mux),
    .redirect_i (targets), .trap_ctrl_i (trap_ctrl), .clear_instr_valid_i (clear_valid),
    .halt_if_i (halt_if), .id_ready_i (id_ready), .imem_rsp_i (imem_rsp),
    .imem_req_o (imem_req), .id_o (id_bundle), .pc_if_o (pc_if),
    .if_busy_o (if_busy), .perf_imiss_o (perf_imiss)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // galois, taps 32 22 2 1
  endfunction

  function automatic logic [`IF_XLEN-1:0] trap_target(input if_pkg::trap_ctrl_t tc);
    logic [`IF_TRAP_BASE_W-1:0] base;
    base = (tc.trap_sel == if_pkg::TRAP_USER) ? tc.u_base : tc.m_base;
    case (tc.exc_sel)
      if_pkg::EXC_PC_IRQ:   return {base, 1'b0, tc.vec_idx, 2'b00};
      if_pkg::EXC_PC_DEBUG: return `IF_DM_HALT_ADDR;
      default:              return {base, 8'h00};
    endcase
  endfunction

  task automatic stop_failed(input bit wrong_value, input string msg);
    if (wrong_value) $display("ERR %0t: %s", $time, msg);
    else $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  // ------------------------------------------------------------------------
  // memory: one lfsr bit for grant, one for answering the oldest request
  // ------------------------------------------------------------------------
  assign imem_rsp = {gnt_en & imem_req.req, rsp_rvalid, rsp_rdata};

  always @(posedge clk) begin : mem_model
    if (rst_n && imem_req.req && imem_rsp.gnt) pend_q.push_back(imem_req.addr);
    #2;
    gnt_en     = lfsr_q[0];
    lfsr_q     = lfsr_step(lfsr_q);
    rsp_rvalid = 1'b0;
    if (rst_n && lfsr_q[0] && pend_q.size() != 0) begin
      rsp_rvalid = 1'b1;
      rsp_rdata  = pend_q.pop_front() ^ RDATA_MASK;
    end
    lfsr_q = lfsr_step(lfsr_q);
  end

  // a load shows up as valid rising or a new pc in IF/ID
  assign new_item = id_bundle.valid && (!last_valid_q || id_bundle.pc != last_pc_q);

  always @(posedge clk or negedge rst_n) begin : track
    if (!rst_n) begin
      last_valid_q <= 1'b0;
      last_pc_q    <= '0;
      exp_pc       <= '0;
      loads        <= 0;
    end else begin
      last_valid_q <= id_bundle.valid;
      last_pc_q    <= id_bundle.pc;
      if (new_item) loads <= loads + 1;
      if (redir) exp_pc <= redir_pc;                // new path starts at the target
      else if (new_item) exp_pc <= exp_pc + 32'd4;  // sequential step
    end
  end

  // ------------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------------
  a_quiet_before_req : assert property (@(posedge clk) disable iff (!rst_n)
    !booted |-> (!imem_req.req && !id_bundle.valid && !if_busy))
    else stop_failed(1'b1, "fetch activity before req was raised");

  a_fetch_order : assert property (@(posedge clk) disable iff (!rst_n)
    new_item |-> (id_bundle.pc == exp_pc) && (id_bundle.instr == (id_bundle.pc ^ RDATA_MASK)))
    else stop_failed(1'b1, "IF/ID pc or instr differs from the expected fetch order");

  // the head that was loaded was on the expected path and counted as a hit
  a_head_pc : assert property (@(posedge clk) disable iff (!rst_n)
    new_item |-> ($past(pc_if) == exp_pc) && !$past(perf_imiss))
    else stop_failed(1'b1, "fetch head pc or miss flag wrong at an IF/ID load");

  // flushed fifo is empty for at least the cycle after the redirect
  a_redirect_miss : assert property (@(posedge clk) disable iff (!rst_n)
    pc_set |-> (perf_imiss && if_busy) ##1 perf_imiss)
    else stop_failed(1'b1, "miss or busy flag low around a redirect");

  a_stall_hold : assert property (@(posedge clk) disable iff (!rst_n)
    ((!id_ready || halt_if) && !clear_valid) |=> $stable(id_bundle))
    else stop_failed(1'b1, "IF/ID changed while ID stalled or IF halted");

  a_clear_valid : assert property (@(posedge clk) disable iff (!rst_n)
    (clear_valid && !id_ready) |=> !id_bundle.valid)
    else stop_failed(1'b1, "valid still set after clear_instr_valid");

  a_req_hold : assert property (@(posedge clk) disable iff (!rst_n)
    (imem_req.req && !imem_rsp.gnt) |=> (pc_set || (imem_req.req && $stable(imem_req.addr))))
    else stop_failed(1'b1, "request dropped or moved before its grant");

  // ------------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------------
  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic wait_loads(input int n, input string what);
    int start;
    int cyc;
    start = loads;
    cyc   = 0;
    while ((loads - start) < n && cyc < WAIT_LIMIT) begin
      @(posedge clk);
      cyc++;
    end
    if ((loads - start) < n) stop_failed(1'b0, {"no instructions reached ID after ", what});
    #2;
  endtask

  task automatic redirect_to(input if_pkg::pc_sel_e sel, input logic [31:0] tgt,
                             input string what);
    pc_mux   = sel;
    pc_set   = 1'b1;
    redir    = 1'b1;
    redir_pc = tgt;
    step(1);
    pc_set = 1'b0;
    redir  = 1'b0;
    wait_loads(4, what);
  endtask

  initial begin : stimulus
    rst_n       = 1'b0;
    req         = 1'b0;
    pc_set      = 1'b0;
    clear_valid = 1'b0;
    halt_if     = 1'b0;
    id_ready    = 1'b1;
    pc_mux      = if_pkg::PC_BOOT;
    targets = '{boot_addr: 32'h0000_1082, jump_id: 32'h0000_4000, branch_ex: 32'h0000_5100,
                mepc: 32'h0000_6204, uepc: 32'h0000_7308, depc: 32'h0000_8400};
    trap_ctrl = '{m_base: 24'h000300, u_base: 24'h000500, trap_sel: if_pkg::TRAP_MACHINE,
                  exc_sel: if_pkg::EXC_PC_EXCEPTION, vec_idx: 5'd19};
    gnt_en      = 1'b0;
    rsp_rvalid  = 1'b0;
    rsp_rdata   = '0;
    lfsr_q      = 32'hcb8d_decc;
    booted      = 1'b0;
    redir       = 1'b0;
    redir_pc    = '0;

    step(10);
    rst_n = 1'b1;
    step(4);  // idle with req low

    // boot: req in IDLE fetches from the aligned boot address
    req      = 1'b1;
    booted   = 1'b1;
    redir    = 1'b1;
    redir_pc = targets.boot_addr & ~32'h3;
    step(1);
    redir = 1'b0;
    wait_loads(8, "boot");

    redirect_to(if_pkg::PC_JUMP,   targets.jump_id,   "jump");
    redirect_to(if_pkg::PC_BRANCH, targets.branch_ex, "branch");
    redirect_to(if_pkg::PC_MRET,   targets.mepc,      "mret");
    redirect_to(if_pkg::PC_URET,   targets.uepc,      "uret");
    redirect_to(if_pkg::PC_DRET,   targets.depc,      "dret");

    // hold ID one cycle, then the word after the ID pc is the next expected pc
    id_ready = 1'b0;
    step(1);
    id_ready = 1'b1;
    redirect_to(if_pkg::PC_FENCEI, exp_pc, "fence.i");

    for (int t = 0; t < 2; t++) begin
      for (int e = 0; e < 3; e++) begin
        trap_ctrl.trap_sel = if_pkg::trap_sel_e'(t[0]);
        trap_ctrl.exc_sel  = if_pkg::exc_sel_e'(e[1:0]);
        redirect_to(if_pkg::PC_EXCEPTION, trap_target(trap_ctrl), "trap redirect");
      end
    end

    // back-pressure, fifo fills while ID is blocked
    id_ready = 1'b0;
    step(8);
    id_ready = 1'b1;
    halt_if  = 1'b1;
    step(6);
    halt_if = 1'b0;
    wait_loads(4, "stall release");

    // kill the word in ID while nothing loads
    id_ready    = 1'b0;
    clear_valid = 1'b1;
    step(1);
    clear_valid = 1'b0;
    step(3);
    id_ready = 1'b1;
    wait_loads(3, "clear_instr_valid");

    step(5);
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+design
design/if_pkg.sv
design/if_next_pc.sv
design/if_prefetch_buffer.sv
design/if_fetch_ctrl.sv
design/if_stage.sv
verif/tb_if_stage.sv

//--- run.sh
#!/bin/sh
# compile and run the fetch stage testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f build.f --top-module tb_if_stage -o sim_if_stage

# the pipe keeps the log even when the simulation aborts
./obj_dir/sim_if_stage | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
grep -q "TEST PASSED" sim.log
